// File: sim.f
source/nnPkg.sv
source/cycleTimer.sv
source/inferenceControl.sv
source/featureLoader.sv
source/neuronNode.sv
source/denseLayer.sv
source/classSelect.sv
source/inferenceTop.sv
tests/inferenceTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module inferenceTb \
	-f sim.f -o inferenceSim

simOutput=$(./obj_dir/inferenceSim)
echo "$simOutput"

# Fails the script unless the pass line is present
echo "$simOutput" | grep -qx "TEST OK"

// File: tests/inferenceTb.sv
module inferenceTb;

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 4;
	localparam int IdleCycles = 8;
	localparam int NumTests = 10;
	localparam int Margin = 30;
	localparam logic [31:0] LfsrTaps = 32'h80200003;

	localparam logic [1:0] KindZero = 2'd0;
	localparam logic [1:0] KindHot = 2'd1;
	localparam logic [1:0] KindRandom = 2'd2;

	typedef struct packed {
		logic [1:0] kind;
		logic [3:0] hotIndex;
		nnPkg::featureWord hotValue;
		logic [3:0] gap;
		logic busyStrobes;
	} stimEntry;

	// Kind, hot position, hot value, strobe gap, strobes while busy
	localparam stimEntry StimTable [NumTests] = '{
		'{KindZero, 4'd0, 16'h0000, 4'd0, 1'b0},
		'{KindHot, 4'd0, 16'hFFFF, 4'd0, 1'b0},
		'{KindHot, 4'd14, 16'h8000, 4'd1, 1'b0},
		'{KindRandom, 4'd0, 16'h0000, 4'd0, 1'b0},
		'{KindRandom, 4'd0, 16'h0000, 4'd0, 1'b0},
		'{KindRandom, 4'd0, 16'h0000, 4'd2, 1'b0},
		'{KindRandom, 4'd0, 16'h0000, 4'd5, 1'b0},
		'{KindRandom, 4'd0, 16'h0000, 4'd1, 1'b1},
		'{KindRandom, 4'd0, 16'h0000, 4'd0, 1'b0},
		'{KindHot, 4'd7, 16'h0001, 4'd0, 1'b0}
	};

	string testNames [NumTests] = '{"zeros", "hotFirst", "hotLast", "randomA", "randomB",
		"randomGap2", "randomGap5", "busyStrobes", "afterBusy", "tieSmallHot"};

	logic clk;
	logic reset;
	logic featureValid;
	nnPkg::featureWord featureData;
	logic busy;
	logic resultValid;
	nnPkg::classIndex resultClass;
	nnPkg::scoreSet resultScores;

	nnPkg::featureWord [nnPkg::FeatureCount-1:0] vectors [NumTests];
	nnPkg::scoreSet expScores [NumTests];
	nnPkg::classIndex expClass [NumTests];
	nnPkg::classIndex heldClass;
	nnPkg::scoreSet heldScores;
	logic [31:0] lfsrState;
	int errorCount = 0;
	int pulseCount = 0;
	int currentTest = 0;

	inferenceTop i_inferenceTop (
		.clk(clk),
		.reset(reset),
		.featureValid(featureValid),
		.featureData(featureData),
		.busy(busy),
		.resultValid(resultValid),
		.resultClass(resultClass),
		.resultScores(resultScores)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	// One LFSR step per bit taken
	function automatic nnPkg::featureWord randomWord();
		nnPkg::featureWord word;
		logic outBit;
		word = '0;
		for (int b = 0; b < 16; b++)
		begin
			outBit = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (outBit)
				lfsrState = lfsrState ^ LfsrTaps;
			word = {word[14:0], outBit};
		end
		return word;
	endfunction

	function automatic nnPkg::activation reluRescale(input logic [31:0] sum);
		if (sum[31])
			return '0;
		return {16'd0, sum[28:13]};
	endfunction

	// Sent feature i lands at loader position FeatureCount-1-i
	function automatic void modelScores(input nnPkg::featureWord [nnPkg::FeatureCount-1:0] sent,
		output nnPkg::scoreSet scores, output nnPkg::classIndex best);
		logic [31:0] sum;
		nnPkg::activation [nnPkg::HiddenCount-1:0] hidden;
		nnPkg::activation [nnPkg::OutputCount-1:0] outs;
		for (int n = 0; n < nnPkg::HiddenCount; n++)
		begin
			sum = nnPkg::HiddenBias[n];
			for (int k = 0; k < nnPkg::FeatureCount; k++)
				sum = sum + nnPkg::HiddenWeights[n][k] * {16'd0, sent[nnPkg::FeatureCount-1-k]};
			hidden[n] = reluRescale(sum);
		end
		for (int n = 0; n < nnPkg::OutputCount; n++)
		begin
			sum = nnPkg::OutputBias[n];
			for (int k = 0; k < nnPkg::HiddenCount; k++)
				sum = sum + nnPkg::OutputWeights[n][k] * hidden[k];
			outs[n] = reluRescale(sum);
		end
		best = '0;
		for (int n = 1; n < nnPkg::OutputCount; n++)
		begin
			if (outs[n] > outs[best])
				best = nnPkg::classIndex'(n);
		end
		scores.class0 = outs[0];
		scores.class1 = outs[1];
		scores.class2 = outs[2];
	endfunction

	function automatic int timeoutCycles();
		int maxGap;
		maxGap = 0;
		for (int t = 0; t < NumTests; t++)
		begin
			if (int'(StimTable[t].gap) > maxGap)
				maxGap = int'(StimTable[t].gap);
		end
		return ResetCycles + IdleCycles + NumTests * (nnPkg::FeatureCount * (1 + maxGap) +
			2 * nnPkg::LayerLatency + Margin);
	endfunction

	task automatic reportMismatch(input string name, input string what,
		input logic [95:0] expected, input logic [95:0] actual);
		errorCount++;
		$display("CHECK FAILED %s %s expected %h actual %h", name, what, expected, actual);
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		$display("ERROR: %s", msg);
	endtask

	task automatic buildTable();
		nnPkg::featureWord [nnPkg::FeatureCount-1:0] vec;
		for (int t = 0; t < NumTests; t++)
		begin
			vec = '0;
			if (StimTable[t].kind == KindHot)
				vec[StimTable[t].hotIndex] = StimTable[t].hotValue;
			else if (StimTable[t].kind == KindRandom)
				for (int i = 0; i < nnPkg::FeatureCount; i++)
					vec[i] = randomWord();
			vectors[t] = vec;
			modelScores(vec, expScores[t], expClass[t]);
		end
	endtask

	// Returns with the last strobe still driven
	task automatic sendVector(input int t);
		for (int i = 0; i < nnPkg::FeatureCount; i++)
		begin
			@(posedge clk);
			if ((i != 0) && (StimTable[t].gap != 4'd0))
			begin
				featureValid <= 1'b0;
				repeat (int'(StimTable[t].gap)) @(posedge clk);
			end
			featureValid <= 1'b1;
			featureData <= vectors[t][i];
		end
	endtask

	// Junk strobes from the cycle after the last feature, while the hidden layer works
	task automatic sendBusyStrobes();
		for (int j = 0; j < nnPkg::LayerLatency; j++)
		begin
			@(posedge clk);
			featureValid <= 1'b1;
			featureData <= randomWord();
			@(negedge clk);
			assert (busy)
				else reportProblem("busy was low while strobes were sent during an inference");
		end
	endtask

	task automatic checkResult(input int t);
		do @(negedge clk); while (!resultValid);
		assert (resultScores == expScores[t])
			else reportMismatch(testNames[t], "scores", expScores[t], resultScores);
		assert (resultClass == expClass[t])
			else reportMismatch(testNames[t], "class", 96'(expClass[t]), 96'(resultClass));
		@(negedge clk);
		assert (!resultValid)
			else reportProblem({"resultValid stayed high after one cycle in ", testNames[t]});
		assert (!busy)
			else reportProblem({"busy did not fall after the result of ", testNames[t]});
	endtask

	// Result outputs must hold between pulses, starting from reset zeros
	initial
	begin
		heldClass = '0;
		heldScores = '0;
		wait (reset === 1'b0);
		forever
		begin
			@(negedge clk);
			if (resultValid)
			begin
				pulseCount++;
				heldClass = resultClass;
				heldScores = resultScores;
			end
			else
			begin
				assert (resultClass == heldClass)
					else reportMismatch(testNames[currentTest], "held class",
						96'(heldClass), 96'(resultClass));
				assert (resultScores == heldScores)
					else reportMismatch(testNames[currentTest], "held scores",
						heldScores, resultScores);
			end
		end
	end

	initial
	begin
		#(timeoutCycles() * ClockPeriod);
		$display("ERROR: run timed out waiting for the DUT, errors so far %0d", errorCount);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		featureValid = 1'b0;
		featureData = '0;
		lfsrState = 32'h5093;
		buildTable();
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		repeat (IdleCycles)
		begin
			@(negedge clk);
			assert (!busy && !resultValid)
				else reportProblem("busy or resultValid high while idle after reset");
		end
		for (int t = 0; t < NumTests; t++)
		begin
			currentTest = t;
			sendVector(t);
			if (StimTable[t].busyStrobes)
				sendBusyStrobes();
			@(posedge clk);
			featureValid <= 1'b0;
			checkResult(t);
		end
		repeat (4) @(negedge clk);
		assert (pulseCount == NumTests)
			else reportMismatch("all", "pulse count", 96'(NumTests), 96'(pulseCount));
		$display("Errors: %0d, vectors: %0d, result pulses: %0d", errorCount, NumTests,
			pulseCount);
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: source/inferenceTop.sv
module inferenceTop #(
	parameter int FeatureCount = nnPkg::FeatureCount,
	parameter int HiddenCount = nnPkg::HiddenCount,
	parameter int OutputCount = nnPkg::OutputCount,
	parameter nnPkg::weight [HiddenCount-1:0][FeatureCount-1:0] HiddenWeights =
		nnPkg::HiddenWeights,
	parameter nnPkg::weight [HiddenCount-1:0] HiddenBias = nnPkg::HiddenBias,
	parameter nnPkg::weight [OutputCount-1:0][HiddenCount-1:0] OutputWeights =
		nnPkg::OutputWeights,
	parameter nnPkg::weight [OutputCount-1:0] OutputBias = nnPkg::OutputBias
) (
	input logic clk,
	input logic reset,
	input logic featureValid,
	input nnPkg::featureWord featureData,
	output logic busy,
	output logic resultValid,
	output nnPkg::classIndex resultClass,
	output nnPkg::scoreSet resultScores
);

	logic timerLoad;
	logic timerStep;
	logic [3:0] loadValue;
	logic expired;
	logic shiftEnable;
	logic capture;
	nnPkg::activation [FeatureCount-1:0] features;
	nnPkg::activation [HiddenCount-1:0] hiddenOut;
	nnPkg::activation [OutputCount-1:0] outputScores;

	inferenceControl #(
		.FeatureCount(FeatureCount),
		.LayerLatency(nnPkg::LayerLatency)
	) i_inferenceControl (
		.clk(clk),
		.reset(reset),
		.featureValid(featureValid),
		.expired(expired),
		.timerLoad(timerLoad),
		.timerStep(timerStep),
		.loadValue(loadValue),
		.shiftEnable(shiftEnable),
		.capture(capture),
		.busy(busy),
		.resultValid(resultValid)
	);

	cycleTimer i_cycleTimer (
		.clk(clk),
		.reset(reset),
		.load(timerLoad),
		.loadValue(loadValue),
		.step(timerStep),
		.expired(expired)
	);

	featureLoader #(
		.FeatureCount(FeatureCount)
	) i_featureLoader (
		.clk(clk),
		.reset(reset),
		.shiftEnable(shiftEnable),
		.featureData(featureData),
		.features(features)
	);

	denseLayer #(
		.InputCount(FeatureCount),
		.NeuronCount(HiddenCount),
		.Weights(HiddenWeights),
		.Biases(HiddenBias)
	) i_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.outputs(hiddenOut)
	);

	denseLayer #(
		.InputCount(HiddenCount),
		.NeuronCount(OutputCount),
		.Weights(OutputWeights),
		.Biases(OutputBias)
	) i_outputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenOut),
		.outputs(outputScores)
	);

	classSelect #(
		.ClassCount(OutputCount)
	) i_classSelect (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.scores(outputScores),
		.bestClass(resultClass),
		.scoreOut(resultScores)
	);

endmodule

// File: source/classSelect.sv
module classSelect #(
	parameter int ClassCount = nnPkg::OutputCount
) (
	input logic clk,
	input logic reset,
	input logic capture,
	input nnPkg::activation [ClassCount-1:0] scores,
	output nnPkg::classIndex bestClass,
	output nnPkg::scoreSet scoreOut
);

	nnPkg::classIndex bestNow;

	// Strict compare keeps the lower index on a tie
	always_comb
	begin
		bestNow = '0;
		for (int i = 1; i < ClassCount; i++)
		begin
			if (scores[i] > scores[bestNow])
				bestNow = nnPkg::classIndex'(i);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bestClass <= '0;
			scoreOut <= '0;
		end
		else if (capture)
		begin
			bestClass <= bestNow;
			scoreOut.class0 <= scores[0];
			scoreOut.class1 <= scores[1];
			scoreOut.class2 <= scores[2];
		end
	end

endmodule

// File: source/denseLayer.sv
module denseLayer #(
	parameter int InputCount = nnPkg::FeatureCount,
	parameter int NeuronCount = nnPkg::HiddenCount,
	parameter nnPkg::weight [NeuronCount-1:0][InputCount-1:0] Weights = '0,
	parameter nnPkg::weight [NeuronCount-1:0] Biases = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::activation [InputCount-1:0] inputs,
	output nnPkg::activation [NeuronCount-1:0] outputs
);

	genvar n;

	// Every neuron sees the same inputs
	generate
		for (n = 0; n < NeuronCount; n++)
		begin : g_neuron
			neuronNode #(
				.InputCount(InputCount),
				.Weights(Weights[n]),
				.Bias(Biases[n])
			) i_neuronNode (
				.clk(clk),
				.reset(reset),
				.inputs(inputs),
				.result(outputs[n])
			);
		end
	endgenerate

endmodule

// File: source/neuronNode.sv
module neuronNode #(
	parameter int InputCount = nnPkg::FeatureCount,
	parameter nnPkg::weight [InputCount-1:0] Weights = '0,
	parameter nnPkg::weight Bias = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::activation [InputCount-1:0] inputs,
	output nnPkg::activation result
);

	nnPkg::activation [InputCount-1:0] inputReg;
	nnPkg::activation weightedSum;
	nnPkg::activation sumReg;

	// Products wrap to 32 bits, as does the running sum
	always_comb
	begin
		weightedSum = nnPkg::activation'(Bias);
		for (int i = 0; i < InputCount; i++)
		begin
			weightedSum = weightedSum + (inputReg[i] * Weights[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			inputReg <= inputs;
			sumReg <= weightedSum;
			// ReLU, then drop the 13 fraction bits
			if (!sumReg[31])
				result <= {16'd0, sumReg[28:13]};
			else
				result <= '0;
		end
	end

endmodule

// File: source/featureLoader.sv
module featureLoader #(
	parameter int FeatureCount = nnPkg::FeatureCount
) (
	input logic clk,
	input logic reset,
	input logic shiftEnable,
	input nnPkg::featureWord featureData,
	output nnPkg::activation [FeatureCount-1:0] features
);

	nnPkg::featureWord [FeatureCount-1:0] shiftReg;

	// Newest word enters at position 0
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			shiftReg <= '0;
		end
		else if (shiftEnable)
		begin
			shiftReg <= {shiftReg[FeatureCount-2:0], featureData};
		end
	end

	always_comb
	begin
		for (int k = 0; k < FeatureCount; k++)
		begin
			features[k] = nnPkg::activation'(shiftReg[k]);
		end
	end

endmodule

// File: source/inferenceControl.sv
module inferenceControl #(
	parameter int FeatureCount = nnPkg::FeatureCount,
	parameter int LayerLatency = nnPkg::LayerLatency
) (
	input logic clk,
	input logic reset,
	input logic featureValid,
	input logic expired,
	output logic timerLoad,
	output logic timerStep,
	output logic [3:0] loadValue,
	output logic shiftEnable,
	output logic capture,
	output logic busy,
	output logic resultValid
);

	nnPkg::controlState state;
	nnPkg::controlState nextState;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= nnPkg::Idle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		timerLoad = 1'b0;
		timerStep = 1'b0;
		loadValue = 4'(LayerLatency);
		shiftEnable = 1'b0;
		capture = 1'b0;
		case (state)
			nnPkg::Idle:
			begin
				if (featureValid)
				begin
					shiftEnable = 1'b1;
					timerLoad = 1'b1;
					// Features left before the last one
					loadValue = 4'(FeatureCount - 2);
					nextState = nnPkg::Collect;
				end
			end
			nnPkg::Collect:
			begin
				if (featureValid)
				begin
					shiftEnable = 1'b1;
					if (expired)
					begin
						timerLoad = 1'b1;
						nextState = nnPkg::HiddenWait;
					end
					else
					begin
						timerStep = 1'b1;
					end
				end
			end
			nnPkg::HiddenWait:
			begin
				if (expired)
				begin
					timerLoad = 1'b1;
					nextState = nnPkg::OutputWait;
				end
				else
				begin
					timerStep = 1'b1;
				end
			end
			nnPkg::OutputWait:
			begin
				if (expired)
				begin
					capture = 1'b1;
					nextState = nnPkg::Report;
				end
				else
				begin
					timerStep = 1'b1;
				end
			end
			nnPkg::Report:
			begin
				nextState = nnPkg::Idle;
			end
			default:
			begin
				nextState = nnPkg::Idle;
			end
		endcase
	end

	assign busy = (state == nnPkg::HiddenWait) || (state == nnPkg::OutputWait) ||
		(state == nnPkg::Report);
	assign resultValid = (state == nnPkg::Report);

endmodule

// File: source/cycleTimer.sv
module cycleTimer (
	input logic clk,
	input logic reset,
	input logic load,
	input logic [3:0] loadValue,
	input logic step,
	output logic expired
);

	logic [3:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= 4'd0;
		end
		else if (load)
		begin
			count <= loadValue;
		end
		else if (step && (count != 4'd0))
		begin
			count <= count - 4'd1;
		end
	end

	assign expired = (count == 4'd0);

endmodule

// File: source/nnPkg.sv
package nnPkg;

	typedef logic [15:0] featureWord;
	typedef logic [31:0] activation;
	typedef logic signed [31:0] weight;
	typedef logic [1:0] classIndex;

	localparam int FeatureCount = 15;
	localparam int HiddenCount = 4;
	localparam int OutputCount = 3;
	localparam int LayerLatency = 3;

	typedef enum logic [2:0] {Idle, Collect, HiddenWait, OutputWait, Report} controlState;

	typedef struct packed {
		activation class2;
		activation class1;
		activation class0;
	} scoreSet;

	// Rows run from the highest neuron down to neuron 0
	localparam weight [HiddenCount-1:0][FeatureCount-1:0] HiddenWeights = '{
		'{2210, -1540, 3071, 880, -2450, 1312, -640, 2905,
			-1875, 455, 3390, -2120, 1760, -990, 2480},
		'{-3150, 2675, -410, 1985, 3220, -2760, 1105, -345,
			2540, -1930, 705, 2890, -3480, 1620, -205},
		'{1480, 3305, -2215, -1190, 925, 2015, -3045, 1770,
			395, 2660, -1460, -835, 3125, 2275, -1650},
		'{-2890, 1645, 2530, -715, -1865, 3010, 1340, -2405,
			-560, 3475, 2105, -1295, -3060, 865, 1935}
	};

	localparam weight [HiddenCount-1:0] HiddenBias = '{-4096, 0, -2048, 0};

	localparam weight [OutputCount-1:0][HiddenCount-1:0] OutputWeights = '{
		'{1875, -2340, 2960, 1415},
		'{-1520, 2785, 1190, -2605},
		'{3140, 1060, -2275, 2430}
	};

	// Classes 0 and 1 share a bias
	localparam weight [OutputCount-1:0] OutputBias = '{8192, 24576, 24576};

endpackage
